// ==== common/rename_cfg_pkg.sv ====
/* Sizing of the rename core, shared by every block below the top:
   register counts, reorder-buffer depth and the widths derived from them */
package rename_cfg_pkg;

    ////////////////////////////////////////
    // Register file and buffer sizes
    ////////////////////////////////////////

    // Architectural registers seen by software
    localparam int ARCH_REGS = 8;
    // Physical tags behind them
    localparam int PHYS_REGS = 14;
    // Tags left over once every arch register holds one
    localparam int FREE_TAGS = PHYS_REGS - ARCH_REGS;
    // In-flight instruction window
    localparam int ROB_DEPTH = 8;

    ////////////////////////////////////////
    // Width typedefs
    ////////////////////////////////////////

    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]   phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;
    // One wider than the index so a full buffer can be counted
    typedef logic [$clog2(ROB_DEPTH+1)-1:0] rob_count_t;

endpackage

// ==== common/rob_pkg.sv ====
/* Reorder-buffer entry state, used by the buffer itself and by
   the bound checker that watches completions */
package rob_pkg;

    // Bits per entry state
    localparam int ROB_STATUS_W = 2;

    // Entry life cycle
    //   EMPTY   slot free
    //   PENDING dispatched, waiting for completion
    //   DONE    completed, waiting to reach the head
    typedef enum logic [ROB_STATUS_W-1:0] {
        ROB_EMPTY   = 2'd0,
        ROB_PENDING = 2'd1,
        ROB_DONE    = 2'd2
    } rob_status_e;

endpackage

// ==== hw/rename/rename_map.sv ====
/* Speculative register map: arch register to physical tag.
   Three combinational read ports, one write port at the clock edge */
`timescale 1ns/1ps

module rename_map (
    input  logic                  clock,
    input  logic                  rst_n,
    // Source lookups
    input  rename_cfg_pkg::arch_reg_t rs1,
    input  rename_cfg_pkg::arch_reg_t rs2,
    output rename_cfg_pkg::phys_tag_t rs1_tag,
    output rename_cfg_pkg::phys_tag_t rs2_tag,
    // Destination lookup, gives the tag about to be superseded
    input  rename_cfg_pkg::arch_reg_t rd,
    output rename_cfg_pkg::phys_tag_t rd_old_tag,
    // New mapping from the renamer
    input  logic                  wr_en,
    input  rename_cfg_pkg::arch_reg_t wr_reg,
    input  rename_cfg_pkg::phys_tag_t wr_tag
);

    import rename_cfg_pkg::*;

    // One tag per architectural register
    phys_tag_t map_q [ARCH_REGS];

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Reads see the table before this cycle's write
    assign rs1_tag    = map_q[rs1];
    assign rs2_tag    = map_q[rs2];
    assign rd_old_tag = map_q[rd];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Identity map, register r owns tag r
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else if (wr_en) begin
            map_q[wr_reg] <= wr_tag;
        end
    end

endmodule

// ==== hw/rename/free_tag_fifo.sv ====
/* Circular FIFO of unallocated physical tags; pops feed the renamer,
   pushes come from retirement. Starts full with the spare tags */
`timescale 1ns/1ps

module free_tag_fifo (
    input  logic                      clock,
    input  logic                      rst_n,
    // Allocation side
    input  logic                      pop,
    output rename_cfg_pkg::phys_tag_t head_tag,
    output logic                      empty,
    // Release side
    input  logic                      push,
    input  rename_cfg_pkg::phys_tag_t push_tag
);

    import rename_cfg_pkg::*;

    typedef logic [$clog2(FREE_TAGS)-1:0]   ptr_t;
    typedef logic [$clog2(FREE_TAGS+1)-1:0] cnt_t;

    phys_tag_t slots_q [FREE_TAGS];
    ptr_t      head_ptr;
    ptr_t      tail_ptr;
    cnt_t      count;

    // Oldest free tag goes out first
    assign head_tag = slots_q[head_ptr];
    assign empty    = (count == '0);

    ////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Spare tags in ascending order, ARCH_REGS upward
            for (int i = 0; i < FREE_TAGS; i++) begin
                slots_q[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            head_ptr <= '0;
            // Full, so tail has wrapped back onto head
            tail_ptr <= '0;
            count    <= cnt_t'(FREE_TAGS);
        end else begin
            if (pop) begin
                head_ptr <= (head_ptr == ptr_t'(FREE_TAGS - 1)) ? '0 : head_ptr + 1'b1;
            end
            if (push) begin
                slots_q[tail_ptr] <= push_tag;
                tail_ptr <= (tail_ptr == ptr_t'(FREE_TAGS - 1)) ? '0 : tail_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/rename/rename_stage.sv ====
/* Rename side: takes one instruction per valid/ready transfer, looks up
   its sources, allocates a destination tag and fills a reorder-buffer slot */
`timescale 1ns/1ps

module rename_stage (
    input  logic                      clock,
    input  logic                      rst_n,
    // Dispatch input
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rename_cfg_pkg::arch_reg_t in_rd,
    input  rename_cfg_pkg::arch_reg_t in_rs1,
    input  rename_cfg_pkg::arch_reg_t in_rs2,
    input  logic                      in_uses_rd,
    // Dispatch report
    output logic                      disp_valid,
    output rename_cfg_pkg::rob_idx_t  disp_rob_idx,
    output rename_cfg_pkg::phys_tag_t disp_src1_tag,
    output rename_cfg_pkg::phys_tag_t disp_src2_tag,
    output rename_cfg_pkg::phys_tag_t disp_dest_tag,
    // Reorder-buffer status and allocation
    input  logic                      rob_full,
    input  rename_cfg_pkg::rob_idx_t  rob_tail_idx,
    output logic                      alloc_valid,
    output rename_cfg_pkg::arch_reg_t alloc_rd,
    output rename_cfg_pkg::phys_tag_t alloc_tag,
    output rename_cfg_pkg::phys_tag_t alloc_old_tag,
    output logic                      alloc_uses_rd,
    // Released tags from retirement
    input  logic                      free_valid,
    input  rename_cfg_pkg::phys_tag_t free_tag
);

    import rename_cfg_pkg::*;

    logic      xfer;
    logic      take_tag;
    logic      fifo_empty;
    phys_tag_t fifo_head_tag;
    phys_tag_t old_tag;
    phys_tag_t dest_tag;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Needs a ROB slot and a spare tag, independent of in_valid
    assign in_ready = !rob_full && !fifo_empty;
    assign xfer     = in_valid && in_ready;
    // Only writers of a destination consume a tag
    assign take_tag = xfer && in_uses_rd;
    assign dest_tag = in_uses_rd ? fifo_head_tag : '0;

    ////////////////////////////////////////
    // Map table and free list
    ////////////////////////////////////////

    rename_map i_map (
        .clock      (clock),
        .rst_n      (rst_n),
        .rs1        (in_rs1),
        .rs2        (in_rs2),
        .rs1_tag    (disp_src1_tag),
        .rs2_tag    (disp_src2_tag),
        .rd         (in_rd),
        .rd_old_tag (old_tag),
        .wr_en      (take_tag),
        .wr_reg     (in_rd),
        .wr_tag     (fifo_head_tag)
    );

    free_tag_fifo i_free (
        .clock    (clock),
        .rst_n    (rst_n),
        .pop      (take_tag),
        .head_tag (fifo_head_tag),
        .empty    (fifo_empty),
        .push     (free_valid),
        .push_tag (free_tag)
    );

    // Same-cycle report of the transfer
    assign disp_valid    = xfer;
    assign disp_rob_idx  = rob_tail_idx;
    assign disp_dest_tag = dest_tag;

    // Entry contents for the reorder buffer
    assign alloc_valid   = xfer;
    assign alloc_rd      = in_rd;
    assign alloc_tag     = dest_tag;
    assign alloc_old_tag = old_tag;
    assign alloc_uses_rd = in_uses_rd;

endmodule

// ==== hw/rob/reorder_buffer.sv ====
/* Reorder buffer: holds dispatched instructions in program order,
   marks them done on completion and hands the head to retirement */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clock,
    input  logic                      rst_n,
    // Allocation from the rename side
    input  logic                      alloc_valid,
    input  rename_cfg_pkg::arch_reg_t alloc_rd,
    input  rename_cfg_pkg::phys_tag_t alloc_tag,
    input  rename_cfg_pkg::phys_tag_t alloc_old_tag,
    input  logic                      alloc_uses_rd,
    output logic                      rob_full,
    output rename_cfg_pkg::rob_idx_t  rob_tail_idx,
    // Completion port
    input  logic                      cmpl_valid,
    input  rename_cfg_pkg::rob_idx_t  cmpl_rob_idx,
    // Head entry toward retirement
    output logic                      retire_valid,
    output rename_cfg_pkg::arch_reg_t retire_rd,
    output rename_cfg_pkg::phys_tag_t retire_tag,
    output rename_cfg_pkg::phys_tag_t retire_old_tag,
    output logic                      retire_uses_rd
);

    import rename_cfg_pkg::*;
    import rob_pkg::*;

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    rob_status_e status_q  [ROB_DEPTH];
    arch_reg_t   rd_q      [ROB_DEPTH];
    phys_tag_t   tag_q     [ROB_DEPTH];
    phys_tag_t   old_tag_q [ROB_DEPTH];
    logic        uses_rd_q [ROB_DEPTH];

    rob_idx_t    head;
    rob_idx_t    tail;
    rob_count_t  count;

    assign rob_full     = (count == rob_count_t'(ROB_DEPTH));
    assign rob_tail_idx = tail;

    // Head leaves as soon as it is done
    assign retire_valid   = (status_q[head] == ROB_DONE);
    assign retire_rd      = rd_q[head];
    assign retire_tag     = tag_q[head];
    assign retire_old_tag = old_tag_q[head];
    assign retire_uses_rd = uses_rd_q[head];

    ////////////////////////////////////////
    // Status and pointers
    ////////////////////////////////////////

    // Allocation hits an EMPTY slot and completion a PENDING one,
    // so the three updates never land on the same entry
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= ROB_EMPTY;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) begin
                status_q[tail] <= ROB_PENDING;
                // Depth is a power of two, pointer wraps by itself
                tail <= tail + 1'b1;
            end
            if (cmpl_valid) begin
                status_q[cmpl_rob_idx] <= ROB_DONE;
            end
            if (retire_valid) begin
                status_q[head] <= ROB_EMPTY;
                head <= head + 1'b1;
            end
            case ({alloc_valid, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload written once at allocation
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            rd_q[tail]      <= alloc_rd;
            tag_q[tail]     <= alloc_tag;
            old_tag_q[tail] <= alloc_old_tag;
            uses_rd_q[tail] <= alloc_uses_rd;
        end
    end

endmodule

// ==== hw/retire_unit.sv ====
/* Retire side: commits the head entry into the architectural map,
   registers the commit report and hands the old tag back to the free list */
`timescale 1ns/1ps

module retire_unit (
    input  logic                      clock,
    input  logic                      rst_n,
    // Head entry from the reorder buffer
    input  logic                      retire_valid,
    input  rename_cfg_pkg::arch_reg_t retire_rd,
    input  rename_cfg_pkg::phys_tag_t retire_tag,
    input  rename_cfg_pkg::phys_tag_t retire_old_tag,
    input  logic                      retire_uses_rd,
    // Commit report, one cycle after the pop
    output logic                      commit_valid,
    output rename_cfg_pkg::arch_reg_t commit_rd,
    output rename_cfg_pkg::phys_tag_t commit_tag,
    output rename_cfg_pkg::phys_tag_t commit_old_tag,
    output logic                      commit_uses_rd,
    // Tag release toward the free list
    output logic                      free_valid,
    output rename_cfg_pkg::phys_tag_t free_tag,
    // Committed-state lookup
    input  rename_cfg_pkg::arch_reg_t arch_query_reg,
    output rename_cfg_pkg::phys_tag_t arch_query_tag
);

    import rename_cfg_pkg::*;

    phys_tag_t arch_map_q [ARCH_REGS];

    // Superseded tag is pushed on the retiring edge itself
    assign free_valid     = retire_valid && retire_uses_rd;
    assign free_tag       = retire_old_tag;
    assign arch_query_tag = arch_map_q[arch_query_reg];

    ////////////////////////////////////////
    // Architectural map
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                arch_map_q[r] <= phys_tag_t'(r);
            end
            commit_valid <= 1'b0;
        end else begin
            if (free_valid) begin
                arch_map_q[retire_rd] <= retire_tag;
            end
            commit_valid <= retire_valid;
        end
    end

    // Report fields, meaningful only with commit_valid
    always_ff @(posedge clock) begin
        if (retire_valid) begin
            commit_rd      <= retire_rd;
            commit_tag     <= retire_tag;
            commit_old_tag <= retire_old_tag;
            commit_uses_rd <= retire_uses_rd;
        end
    end

endmodule

// ==== hw/rename_core.sv ====
/* Top of the rename core: rename side, reorder buffer and retire side.
   Drive dispatch and completion, watch commits and query the arch map */
`timescale 1ns/1ps

module rename_core (
    input  logic       clock,
    input  logic       rst_n,
    // Dispatch
    input  logic       in_valid,
    output logic       in_ready,
    input  logic [2:0] in_rd,
    input  logic [2:0] in_rs1,
    input  logic [2:0] in_rs2,
    input  logic       in_uses_rd,
    output logic       disp_valid,
    output logic [2:0] disp_rob_idx,
    output logic [3:0] disp_src1_tag,
    output logic [3:0] disp_src2_tag,
    output logic [3:0] disp_dest_tag,
    // Completion
    input  logic       cmpl_valid,
    input  logic [2:0] cmpl_rob_idx,
    // Commit
    output logic       commit_valid,
    output logic [2:0] commit_rd,
    output logic [3:0] commit_tag,
    output logic [3:0] commit_old_tag,
    output logic       commit_uses_rd,
    // Arch map query
    input  logic [2:0] arch_query_reg,
    output logic [3:0] arch_query_tag
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    // Rename side to reorder buffer
    logic       rob_full;
    logic [2:0] rob_tail_idx;
    logic       alloc_valid;
    logic [2:0] alloc_rd;
    logic [3:0] alloc_tag;
    logic [3:0] alloc_old_tag;
    logic       alloc_uses_rd;
    // Reorder buffer to retire side
    logic       retire_valid;
    logic [2:0] retire_rd;
    logic [3:0] retire_tag;
    logic [3:0] retire_old_tag;
    logic       retire_uses_rd;
    // Retire side back to the free list
    logic       free_valid;
    logic [3:0] free_tag;

    rename_stage i_rename (
        .clock         (clock),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_rd         (in_rd),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .in_uses_rd    (in_uses_rd),
        .disp_valid    (disp_valid),
        .disp_rob_idx  (disp_rob_idx),
        .disp_src1_tag (disp_src1_tag),
        .disp_src2_tag (disp_src2_tag),
        .disp_dest_tag (disp_dest_tag),
        .rob_full      (rob_full),
        .rob_tail_idx  (rob_tail_idx),
        .alloc_valid   (alloc_valid),
        .alloc_rd      (alloc_rd),
        .alloc_tag     (alloc_tag),
        .alloc_old_tag (alloc_old_tag),
        .alloc_uses_rd (alloc_uses_rd),
        .free_valid    (free_valid),
        .free_tag      (free_tag)
    );

    reorder_buffer i_rob (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc_valid    (alloc_valid),
        .alloc_rd       (alloc_rd),
        .alloc_tag      (alloc_tag),
        .alloc_old_tag  (alloc_old_tag),
        .alloc_uses_rd  (alloc_uses_rd),
        .rob_full       (rob_full),
        .rob_tail_idx   (rob_tail_idx),
        .cmpl_valid     (cmpl_valid),
        .cmpl_rob_idx   (cmpl_rob_idx),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_tag     (retire_tag),
        .retire_old_tag (retire_old_tag),
        .retire_uses_rd (retire_uses_rd)
    );

    retire_unit i_retire (
        .clock          (clock),
        .rst_n          (rst_n),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_tag     (retire_tag),
        .retire_old_tag (retire_old_tag),
        .retire_uses_rd (retire_uses_rd),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_tag     (commit_tag),
        .commit_old_tag (commit_old_tag),
        .commit_uses_rd (commit_uses_rd),
        .free_valid     (free_valid),
        .free_tag       (free_tag),
        .arch_query_reg (arch_query_reg),
        .arch_query_tag (arch_query_tag)
    );

endmodule

// ==== tb/rename_core_chk.sv ====
/* Assertions bound into the rename core on dispatch back-pressure,
   completion targets and the commit port during reset */
`timescale 1ns/1ps

module rename_core_chk (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 in_ready,
    input logic                 rob_full,
    input logic                 cmpl_valid,
    // State of the entry named by the completion port
    input rob_pkg::rob_status_e cmpl_status,
    input logic                 commit_valid
);

    import rob_pkg::*;

    // Number of assertion failures so far
    int assert_fails = 0;

    ////////////////////////////////////////
    // Dispatch and completion
    ////////////////////////////////////////

    // No free slot, no transfer
    a_ready_not_full: assert property (
        @(posedge clock) disable iff (!rst_n) rob_full |-> !in_ready
    ) else begin
        $error("in_ready high while the reorder buffer is full");
        assert_fails++;
    end

    // Only dispatched, not yet completed entries may complete
    a_cmpl_pending: assert property (
        @(posedge clock) disable iff (!rst_n) cmpl_valid |-> (cmpl_status == ROB_PENDING)
    ) else begin
        $error("completion names an entry that is not pending");
        assert_fails++;
    end

    // Commit port quiet while reset is held
    a_commit_in_reset: assert property (
        @(posedge clock) !rst_n |-> !commit_valid
    ) else begin
        $error("commit_valid high during reset");
        assert_fails++;
    end

endmodule

// ==== tb/rename_core_tb.sv ====
/* Rename core testbench. Runs a fixed instruction table through dispatch,
   completes entries in LCG order and checks every report against a reference model */
`timescale 1ns/1ps

module rename_core_tb;

    import rename_cfg_pkg::*;

    localparam int N_INSTR    = 20;
    localparam int MAX_CYCLES = 2000;
    localparam int MAX_STALL  = 64;

    // Table row with payload and expected destination tag
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      uses_rd;
        phys_tag_t exp_dest;
    } instr_t;

    // Program-order record of the model
    typedef struct packed {
        arch_reg_t rd;
        phys_tag_t tag;
        phys_tag_t old_tag;
        logic      uses_rd;
        rob_idx_t  idx;
    } entry_t;

    logic       clock;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    logic [2:0] in_rd;
    logic [2:0] in_rs1;
    logic [2:0] in_rs2;
    logic       in_uses_rd;
    logic       disp_valid;
    logic [2:0] disp_rob_idx;
    logic [3:0] disp_src1_tag;
    logic [3:0] disp_src2_tag;
    logic [3:0] disp_dest_tag;
    logic       cmpl_valid;
    logic [2:0] cmpl_rob_idx;
    logic       commit_valid;
    logic [2:0] commit_rd;
    logic [3:0] commit_tag;
    logic [3:0] commit_old_tag;
    logic       commit_uses_rd;
    logic [2:0] arch_query_reg;
    logic [3:0] arch_query_tag;

    instr_t      program_tbl [N_INSTR];
    // Reference model state
    phys_tag_t   spec_map [ARCH_REGS];
    phys_tag_t   arch_map [ARCH_REGS];
    phys_tag_t   free_q [$];
    entry_t      order_q [$];
    rob_idx_t    pending_q [$];
    logic        done_flag [ROB_DEPTH];
    rob_idx_t    model_tail;
    int          next_instr;
    int          n_commit;
    int          stall_run;
    int          stall_full;
    int          stall_tags;
    logic        stalled;
    logic [31:0] lcg_state;

    rename_core i_dut (.*);

    bind rename_core rename_core_chk i_chk (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_ready     (in_ready),
        .rob_full     (rob_full),
        .cmpl_valid   (cmpl_valid),
        .cmpl_status  (i_rob.status_q[cmpl_rob_idx]),
        .commit_valid (commit_valid)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Watch the bound checker
    always @(negedge clock) begin
        if (i_dut.i_chk.assert_fails != 0) begin
            $display("Bound assertion failed before %0t ns", $time);
            $display("Verification failed");
            $fatal(1, "stopping on assertion failure");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string why);
        $display("Timeout at %0t ns: %s", $time, why);
        $display("Verification failed");
        $fatal(1, "stopping on timeout");
    endtask

    // Writers 0..5 take the spare tags 8..13, writers 14..19 reuse
    // the old tags released by 0..5 in commit order
    task automatic fill_table();
        program_tbl[0]  = '{3'd1, 3'd0, 3'd2, 1'b1, 4'd8};
        program_tbl[1]  = '{3'd2, 3'd1, 3'd1, 1'b1, 4'd9};
        program_tbl[2]  = '{3'd3, 3'd2, 3'd1, 1'b1, 4'd10};
        program_tbl[3]  = '{3'd1, 3'd3, 3'd1, 1'b1, 4'd11};
        program_tbl[4]  = '{3'd4, 3'd1, 3'd3, 1'b1, 4'd12};
        program_tbl[5]  = '{3'd5, 3'd4, 3'd0, 1'b1, 4'd13};
        // Non-writers that fill the reorder buffer
        program_tbl[6]  = '{3'd0, 3'd5, 3'd1, 1'b0, 4'd0};
        program_tbl[7]  = '{3'd7, 3'd2, 3'd4, 1'b0, 4'd0};
        program_tbl[8]  = '{3'd3, 3'd1, 3'd5, 1'b0, 4'd0};
        program_tbl[9]  = '{3'd6, 3'd0, 3'd3, 1'b0, 4'd0};
        program_tbl[10] = '{3'd2, 3'd4, 3'd4, 1'b0, 4'd0};
        program_tbl[11] = '{3'd5, 3'd2, 3'd6, 1'b0, 4'd0};
        program_tbl[12] = '{3'd1, 3'd5, 3'd3, 1'b0, 4'd0};
        program_tbl[13] = '{3'd4, 3'd7, 3'd1, 1'b0, 4'd0};
        program_tbl[14] = '{3'd6, 3'd1, 3'd2, 1'b1, 4'd1};
        program_tbl[15] = '{3'd7, 3'd6, 3'd5, 1'b1, 4'd2};
        program_tbl[16] = '{3'd1, 3'd1, 3'd7, 1'b1, 4'd3};
        program_tbl[17] = '{3'd2, 3'd6, 3'd1, 1'b1, 4'd8};
        program_tbl[18] = '{3'd0, 3'd2, 3'd3, 1'b1, 4'd4};
        program_tbl[19] = '{3'd3, 3'd0, 3'd1, 1'b1, 4'd5};
    endtask

    task automatic init_model();
        for (int r = 0; r < ARCH_REGS; r++) begin
            spec_map[r] = phys_tag_t'(r);
            arch_map[r] = phys_tag_t'(r);
        end
        for (int t = ARCH_REGS; t < PHYS_REGS; t++) begin
            free_q.push_back(phys_tag_t'(t));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            done_flag[i] = 1'b0;
        end
        model_tail = '0;
    endtask

    task automatic check_arch_map();
        for (int r = 0; r < ARCH_REGS; r++) begin
            @(posedge clock);
            arch_query_reg <= arch_reg_t'(r);
            @(negedge clock);
            check(arch_query_tag, arch_map[r], "arch_query_tag");
        end
    endtask

    ////////////////////////////////////////
    // Drive on the rising edge
    ////////////////////////////////////////

    // Completions only while dispatch is stuck or the table is used up
    task automatic drive_inputs();
        int pick;
        if ((stalled || next_instr == N_INSTR) && pending_q.size() != 0) begin
            pick = int'((next_rand() >> 16) % pending_q.size());
            cmpl_valid   <= 1'b1;
            cmpl_rob_idx <= pending_q[pick];
            done_flag[pending_q[pick]] = 1'b1;
            pending_q.delete(pick);
        end else begin
            cmpl_valid <= 1'b0;
        end
        // Payload held until accepted
        if (next_instr < N_INSTR) begin
            in_valid   <= 1'b1;
            in_rd      <= program_tbl[next_instr].rd;
            in_rs1     <= program_tbl[next_instr].rs1;
            in_rs2     <= program_tbl[next_instr].rs2;
            in_uses_rd <= program_tbl[next_instr].uses_rd;
        end else begin
            in_valid <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Observe on the falling edge
    ////////////////////////////////////////

    task automatic observe_commit();
        entry_t e;
        if (commit_valid) begin
            check(order_q.size() != 0, 1'b1, "commit with nothing outstanding");
            e = order_q.pop_front();
            check(done_flag[e.idx], 1'b1, "commit before completion");
            done_flag[e.idx] = 1'b0;
            check(commit_rd, e.rd, "commit_rd");
            check(commit_tag, e.tag, "commit_tag");
            check(commit_old_tag, e.old_tag, "commit_old_tag");
            check(commit_uses_rd, e.uses_rd, "commit_uses_rd");
            if (e.uses_rd) begin
                arch_map[e.rd] = e.tag;
                free_q.push_back(e.old_tag);
            end
            n_commit++;
        end
    endtask

    task automatic observe_ready();
        logic exp_ready;
        // Slot and spare tag both needed
        exp_ready = (order_q.size() < ROB_DEPTH) && (free_q.size() != 0);
        check(in_ready, exp_ready, "in_ready");
        stalled = in_valid && !in_ready;
        if (stalled) begin
            stall_run++;
            if (order_q.size() == ROB_DEPTH) begin
                stall_full++;
            end else begin
                stall_tags++;
            end
            if (stall_run > MAX_STALL) begin
                timeout_fail("in_ready stayed low too long");
            end
        end else begin
            stall_run = 0;
        end
    endtask

    task automatic observe_dispatch();
        instr_t    ins;
        entry_t    e;
        phys_tag_t new_tag;
        ins = program_tbl[next_instr];
        check(disp_valid, 1'b1, "disp_valid");
        check(disp_rob_idx, model_tail, "disp_rob_idx");
        // Sources see the map before this instruction's write
        check(disp_src1_tag, spec_map[ins.rs1], "disp_src1_tag");
        check(disp_src2_tag, spec_map[ins.rs2], "disp_src2_tag");
        new_tag = '0;
        if (ins.uses_rd) begin
            new_tag = free_q.pop_front();
        end
        check(disp_dest_tag, new_tag, "disp_dest_tag");
        check(disp_dest_tag, ins.exp_dest, "disp_dest_tag vs table");
        e = '{rd: ins.rd, tag: new_tag, old_tag: spec_map[ins.rd],
              uses_rd: ins.uses_rd, idx: model_tail};
        order_q.push_back(e);
        pending_q.push_back(model_tail);
        if (ins.uses_rd) begin
            spec_map[ins.rd] = new_tag;
        end
        model_tail++;
        next_instr++;
    endtask

    task automatic run_traffic();
        int cycles;
        cycles = 0;
        while (n_commit < N_INSTR) begin
            @(posedge clock);
            drive_inputs();
            @(negedge clock);
            observe_commit();
            observe_ready();
            if (in_valid && in_ready) begin
                observe_dispatch();
            end else begin
                check(disp_valid, 1'b0, "disp_valid");
            end
            cycles++;
            if (cycles > MAX_CYCLES) begin
                timeout_fail("not every instruction committed");
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_rd          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_uses_rd     = 1'b0;
        cmpl_valid     = 1'b0;
        cmpl_rob_idx   = '0;
        arch_query_reg = '0;
        lcg_state      = 32'd66;
        next_instr     = 0;
        n_commit       = 0;
        stall_run      = 0;
        stall_full     = 0;
        stall_tags     = 0;
        stalled        = 1'b0;
        fill_table();
        init_model();

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check(in_ready, 1'b1, "in_ready after reset");
        check(commit_valid, 1'b0, "commit_valid after reset");
        // Identity map out of reset
        check_arch_map();

        run_traffic();
        // Both kinds of back-pressure seen
        check(stall_tags != 0, 1'b1, "stall on empty free list");
        check(stall_full != 0, 1'b1, "stall on full reorder buffer");
        check(i_dut.i_rename.i_free.count, free_q.size(), "free tag count after drain");
        check_arch_map();

        if (i_dut.i_chk.assert_fails == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Assertion failures: %0d", i_dut.i_chk.assert_fails);
            $display("Verification failed");
            $fatal(1, "stopping after assertion failures");
        end
    end

endmodule

// ==== rename_core.f ====
common/rename_cfg_pkg.sv
common/rob_pkg.sv
hw/rename/rename_map.sv
hw/rename/free_tag_fifo.sv
hw/rename/rename_stage.sv
hw/rob/reorder_buffer.sv
hw/retire_unit.sv
hw/rename_core.sv
tb/rename_core_chk.sv
tb/rename_core_tb.sv
